/* breakout_macros.svh */
// Sizes assume the 160x120 plotter; coordinates are 8 bits, so nothing may sit at 256 or beyond
`ifndef BREAKOUT_MACROS_SVH
`define BREAKOUT_MACROS_SVH

// Playfield
`define SCREEN_W 160
`define SCREEN_H 120
`define COORD_W 8
`define COLOUR_W 3

// Paddle, 16 columns by 2 rows
`define PADDLE_W 16
`define PADDLE_H 2
`define PADDLE_X0 76
`define PADDLE_Y0 110
`define PADDLE_X_MAX 144 // Right edge stop, 160 - 16

`define BALL_X0 80
`define BALL_Y0 108

// One brick row
`define BRICK_W 8
`define BRICK_H 2
`define BRICK_ROW_Y 30
`define BRICK_X0 15
`define BRICK_PITCH 30 // Left edge to left edge
`define NUM_BRICKS 5

// 1 bit per channel, {r, g, b}
`define CLR_BLACK 3'b000
`define CLR_WHITE 3'b111
`define CLR_GREEN 3'b010
`define CLR_RED 3'b100

`define FRAME_CYCLES_DEFAULT 834357 // About 60 Hz at 50 MHz

`endif

/* breakout_pkg.sv */
// Shared game types; point and pixel layouts must match what the pixel adapter expects
`include "breakout_macros.svh"

package breakout_pkg;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} point_t;

	// Plot payload
	typedef struct packed {
		point_t point;
		logic [`COLOUR_W-1:0] colour;
	} pixel_t;

	typedef struct packed {
		logic left; // Active high
		logic right;
	} keys_t;

	typedef enum logic [1:0] {
		SHAPE_SCREEN, // Full 256x256 sweep
		SHAPE_PADDLE,
		SHAPE_BRICK,
		SHAPE_DOT
	} sprite_shape_e;

	// Raster counter, read as {y, x} for full sweeps or as row/column for sprites
	typedef union packed {
		struct packed {
			logic [7:0] y;
			logic [7:0] x;
		} screen;
		struct packed {
			logic [10:0] spare;
			logic row;
			logic [3:0] col;
		} sprite;
	} raster_count_u;

	typedef struct packed {
		sprite_shape_e shape;
		point_t base; // Top left corner, ignored for screen sweeps
		logic [`COLOUR_W-1:0] colour;
	} draw_req_t;

	typedef enum logic [3:0] {
		ST_CLEAR, ST_INIT_PADDLE, ST_INIT_BALL, ST_IDLE,
		ST_ERASE_PADDLE, ST_MOVE_PADDLE, ST_DRAW_PADDLE,
		ST_ERASE_BALL, ST_MOVE_BALL, ST_DRAW_BALL,
		ST_CHECK_BRICK, ST_DRAW_BRICK, ST_DEAD_FILL, ST_HALT
	} game_state_e;

endpackage

/* frame_tick.sv */
// Pulses one cycle every frame_cycles clocks; frame_cycles must exceed the per-frame draw time
`timescale 1ns/1ps
`include "breakout_macros.svh"

module frame_tick #(
	parameter int frame_cycles = `FRAME_CYCLES_DEFAULT
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	output logic tick
);
	localparam int cnt_w = $clog2(frame_cycles); // Holds frame_cycles - 1

	logic [cnt_w-1:0] count;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			count <= cnt_w'(frame_cycles - 1);
			tick <= 1'b0;
		end else if (count == '0) begin
			count <= cnt_w'(frame_cycles - 1); // Reload, period is frame_cycles
			tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* sprite_raster.sv */
// One pixel per cycle with no back-pressure; start must not come before done of the last draw
`timescale 1ns/1ps

module sprite_raster (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic start,
	input  breakout_pkg::draw_req_t draw_req,
	output breakout_pkg::pixel_t pixel,
	output logic plot,
	output logic done
);
	breakout_pkg::draw_req_t req_q;
	breakout_pkg::draw_req_t req_cur;
	breakout_pkg::raster_count_u cnt;
	breakout_pkg::raster_count_u cnt_cur;
	breakout_pkg::raster_count_u cnt_nxt;
	breakout_pkg::point_t pt;
	logic busy;
	logic active;
	logic last;
	logic [3:0] col_last;

	// Start bypasses the latch so the first pixel lands one cycle later
	assign req_cur = start ? draw_req : req_q;
	assign cnt_cur = start ? '0 : cnt;
	assign active = start | busy;

	always_comb begin
		case (req_cur.shape)
			breakout_pkg::SHAPE_PADDLE: col_last = 4'(`PADDLE_W - 1);
			breakout_pkg::SHAPE_BRICK: col_last = 4'(`BRICK_W - 1);
			default: col_last = 4'd0;
		endcase
	end

	always_comb begin
		cnt_nxt = cnt_cur;
		pt = req_cur.base;
		if (req_cur.shape == breakout_pkg::SHAPE_SCREEN) begin
			pt.x = cnt_cur.screen.x; // Off-screen points dropped by the adapter
			pt.y = cnt_cur.screen.y;
			last = (&cnt_cur.screen.x) & (&cnt_cur.screen.y);
			cnt_nxt.screen.x = cnt_cur.screen.x + 8'd1;
			if (&cnt_cur.screen.x)
				cnt_nxt.screen.y = cnt_cur.screen.y + 8'd1; // Next line
		end else begin
			pt.x = req_cur.base.x + {4'd0, cnt_cur.sprite.col};
			pt.y = req_cur.base.y + {7'd0, cnt_cur.sprite.row};
			last = (req_cur.shape == breakout_pkg::SHAPE_DOT) ||
				(cnt_cur.sprite.row && cnt_cur.sprite.col == col_last);
			if (cnt_cur.sprite.col == col_last) begin
				cnt_nxt.sprite.col = 4'd0; // Wrap to row 1
				cnt_nxt.sprite.row = 1'b1;
			end else begin
				cnt_nxt.sprite.col = cnt_cur.sprite.col + 4'd1;
			end
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			plot <= 1'b0;
			done <= 1'b0;
		end else begin
			plot <= active;
			done <= active & last; // Same cycle as the last pixel
			if (active)
				busy <= ~last;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (active) begin
			req_q <= req_cur;
			cnt <= cnt_nxt;
			pixel.point <= pt;
			pixel.colour <= req_cur.colour;
		end
	end

	// Stream goes quiet right after the last pixel
	plot_falls_after_done: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		done |=> !plot);

endmodule

/* game_fsm.sv */
// Frame work only starts from idle on a tick; after the red fill the game halts until reset
`timescale 1ns/1ps
`include "breakout_macros.svh"

module game_fsm (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic tick,
	input  logic done,
	input  logic dead,
	input  breakout_pkg::point_t paddle_pos,
	input  breakout_pkg::point_t ball_pos,
	input  logic [`NUM_BRICKS-1:0][`COLOUR_W-1:0] brick_colour,
	output logic start,
	output breakout_pkg::draw_req_t draw_req,
	output logic load_init,
	output logic paddle_step,
	output logic ball_step,
	output logic brick_check,
	output logic [2:0] brick_idx
);
	breakout_pkg::game_state_e state;
	breakout_pkg::game_state_e state_nxt;
	breakout_pkg::game_state_e prev_state;
	logic entry;
	logic draw_state;
	logic drawing;
	logic last_brick;
	logic [`COORD_W-1:0] brick_x;

	assign entry = (state != prev_state); // First cycle in a state
	assign last_brick = (brick_idx == 3'(`NUM_BRICKS - 1));
	assign brick_x = 8'(`BRICK_X0) + 8'(`BRICK_PITCH) * {5'd0, brick_idx};

	// Unit strobes, one cycle each
	assign load_init = (state == breakout_pkg::ST_CLEAR) && done;
	assign paddle_step = (state == breakout_pkg::ST_MOVE_PADDLE);
	assign ball_step = (state == breakout_pkg::ST_MOVE_BALL);
	assign brick_check = (state == breakout_pkg::ST_CHECK_BRICK);

	always_comb begin
		case (state)
			breakout_pkg::ST_CLEAR, breakout_pkg::ST_INIT_PADDLE, breakout_pkg::ST_INIT_BALL,
			breakout_pkg::ST_ERASE_PADDLE, breakout_pkg::ST_DRAW_PADDLE,
			breakout_pkg::ST_ERASE_BALL, breakout_pkg::ST_DRAW_BALL,
			breakout_pkg::ST_DRAW_BRICK, breakout_pkg::ST_DEAD_FILL: draw_state = 1'b1;
			default: draw_state = 1'b0;
		endcase
	end

	// A lost ball skips its redraw
	assign start = draw_state && entry && !(state == breakout_pkg::ST_DRAW_BALL && dead);

	always_comb begin
		draw_req.shape = breakout_pkg::SHAPE_DOT;
		draw_req.base = ball_pos;
		draw_req.colour = `CLR_WHITE;
		case (state)
			breakout_pkg::ST_CLEAR: begin
				draw_req.shape = breakout_pkg::SHAPE_SCREEN;
				draw_req.base = '0;
				draw_req.colour = `CLR_BLACK;
			end
			breakout_pkg::ST_INIT_PADDLE, breakout_pkg::ST_DRAW_PADDLE: begin
				draw_req.shape = breakout_pkg::SHAPE_PADDLE;
				draw_req.base = paddle_pos;
			end
			breakout_pkg::ST_ERASE_PADDLE: begin
				draw_req.shape = breakout_pkg::SHAPE_PADDLE;
				draw_req.base = paddle_pos;
				draw_req.colour = `CLR_BLACK;
			end
			breakout_pkg::ST_ERASE_BALL: draw_req.colour = `CLR_BLACK;
			breakout_pkg::ST_DRAW_BRICK: begin
				draw_req.shape = breakout_pkg::SHAPE_BRICK;
				draw_req.base.x = brick_x;
				draw_req.base.y = 8'(`BRICK_ROW_Y);
				draw_req.colour = brick_colour[brick_idx]; // Black once knocked out
			end
			breakout_pkg::ST_DEAD_FILL: begin
				draw_req.shape = breakout_pkg::SHAPE_SCREEN;
				draw_req.base = '0;
				draw_req.colour = `CLR_RED;
			end
			default: ; // Ball dot, white
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			breakout_pkg::ST_CLEAR: if (done) state_nxt = breakout_pkg::ST_INIT_PADDLE;
			breakout_pkg::ST_INIT_PADDLE: if (done) state_nxt = breakout_pkg::ST_INIT_BALL;
			breakout_pkg::ST_INIT_BALL: if (done) state_nxt = breakout_pkg::ST_IDLE;
			breakout_pkg::ST_IDLE: if (tick) state_nxt = breakout_pkg::ST_ERASE_PADDLE;
			breakout_pkg::ST_ERASE_PADDLE: if (done) state_nxt = breakout_pkg::ST_MOVE_PADDLE;
			breakout_pkg::ST_MOVE_PADDLE: state_nxt = breakout_pkg::ST_DRAW_PADDLE;
			breakout_pkg::ST_DRAW_PADDLE: if (done) state_nxt = breakout_pkg::ST_ERASE_BALL;
			breakout_pkg::ST_ERASE_BALL: if (done) state_nxt = breakout_pkg::ST_MOVE_BALL;
			breakout_pkg::ST_MOVE_BALL: state_nxt = breakout_pkg::ST_DRAW_BALL;
			breakout_pkg::ST_DRAW_BALL: begin
				if (dead)
					state_nxt = breakout_pkg::ST_DEAD_FILL;
				else if (done)
					state_nxt = breakout_pkg::ST_CHECK_BRICK;
			end
			breakout_pkg::ST_CHECK_BRICK: state_nxt = breakout_pkg::ST_DRAW_BRICK;
			breakout_pkg::ST_DRAW_BRICK: begin
				if (done)
					state_nxt = last_brick ? breakout_pkg::ST_IDLE : breakout_pkg::ST_CHECK_BRICK;
			end
			breakout_pkg::ST_DEAD_FILL: if (done) state_nxt = breakout_pkg::ST_HALT;
			default: state_nxt = breakout_pkg::ST_HALT; // Stays here until reset
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= breakout_pkg::ST_CLEAR;
			prev_state <= breakout_pkg::ST_HALT; // Forces entry on the clear
			brick_idx <= 3'd0;
			drawing <= 1'b0;
		end else begin
			state <= state_nxt;
			prev_state <= state;
			if (state == breakout_pkg::ST_DRAW_BRICK && done)
				brick_idx <= last_brick ? 3'd0 : brick_idx + 3'd1;
			if (start)
				drawing <= 1'b1;
			else if (done)
				drawing <= 1'b0;
		end
	end

	// One draw at a time on the raster
	no_start_mid_draw: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		drawing |-> !start);

endmodule

/* paddle_unit.sv */
// Paddle moves one pixel per step; holding both keys leaves it in place except at the right edge
`timescale 1ns/1ps
`include "breakout_macros.svh"

module paddle_unit (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic load_init,
	input  logic paddle_step,
	input  breakout_pkg::keys_t keys,
	output breakout_pkg::point_t paddle_pos
);
	localparam breakout_pkg::point_t start_pos = '{x: 8'(`PADDLE_X0), y: 8'(`PADDLE_Y0)};

	breakout_pkg::point_t pos_nxt;

	// Right step first and left against the updated x
	always_comb begin
		pos_nxt = paddle_pos;
		if (keys.right && pos_nxt.x < 8'(`PADDLE_X_MAX))
			pos_nxt.x = pos_nxt.x + 8'd1;
		if (keys.left && pos_nxt.x > 8'd0)
			pos_nxt.x = pos_nxt.x - 8'd1;
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n)
			paddle_pos <= start_pos;
		else if (load_init)
			paddle_pos <= start_pos;
		else if (paddle_step)
			paddle_pos <= pos_nxt; // y never changes
	end

endmodule

/* ball_unit.sv */
// Bounce tests use the moved position; x bounces at 160, one column past the visible edge
`timescale 1ns/1ps
`include "breakout_macros.svh"

module ball_unit (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic load_init,
	input  logic ball_step,
	input  breakout_pkg::point_t paddle_pos,
	input  logic brick_hit,
	output breakout_pkg::point_t ball_pos,
	output logic dead
);
	localparam breakout_pkg::point_t start_pos = '{x: 8'(`BALL_X0), y: 8'(`BALL_Y0)};

	breakout_pkg::point_t pos_nxt;
	logic x_left; // 0 moves right
	logic y_down; // 0 moves up
	logic on_paddle;
	logic flip_x;
	logic flip_y;

	always_comb begin
		pos_nxt.x = x_left ? ball_pos.x - 8'd1 : ball_pos.x + 8'd1;
		pos_nxt.y = y_down ? ball_pos.y + 8'd1 : ball_pos.y - 8'd1;
		flip_x = (pos_nxt.x == 8'd0) || (pos_nxt.x == 8'(`SCREEN_W));
		// Only a falling ball bounces off either paddle row
		on_paddle = y_down &&
			(pos_nxt.y == paddle_pos.y || pos_nxt.y == paddle_pos.y + 8'd1) &&
			pos_nxt.x >= paddle_pos.x &&
			pos_nxt.x <= paddle_pos.x + 8'(`PADDLE_W - 1);
		flip_y = (pos_nxt.y == 8'd0) || on_paddle; // Ceiling or paddle
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			ball_pos <= start_pos;
			x_left <= 1'b0;
			y_down <= 1'b0;
			dead <= 1'b0;
		end else if (load_init) begin
			ball_pos <= start_pos;
			x_left <= 1'b0;
			y_down <= 1'b0;
		end else if (ball_step) begin
			ball_pos <= pos_nxt;
			x_left <= x_left ^ flip_x;
			y_down <= y_down ^ flip_y;
			if (pos_nxt.y >= 8'(`SCREEN_H))
				dead <= 1'b1; // Past the bottom
		end else if (brick_hit) begin
			y_down <= ~y_down;
		end
	end

	// Game over sticks until reset
	dead_sticky: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		dead |=> dead);

endmodule

/* brick_wall.sv */
// Fixed single row of bricks; brick_idx beyond the last brick never hits
`timescale 1ns/1ps
`include "breakout_macros.svh"

module brick_wall (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic load_init,
	input  logic brick_check,
	input  logic [2:0] brick_idx,
	input  breakout_pkg::point_t ball_pos,
	output logic brick_hit,
	output logic [`NUM_BRICKS-1:0][`COLOUR_W-1:0] brick_colour
);
	logic [`NUM_BRICKS-1:0] alive;
	logic [`COORD_W-1:0] brick_x;
	logic hit_now;

	always_comb begin
		brick_x = 8'(`BRICK_X0) + 8'(`BRICK_PITCH) * {5'd0, brick_idx}; // Left edge
		hit_now = (brick_idx < 3'(`NUM_BRICKS)) && alive[brick_idx] &&
			(ball_pos.y == 8'(`BRICK_ROW_Y) || ball_pos.y == 8'(`BRICK_ROW_Y + 1)) &&
			ball_pos.x >= brick_x &&
			ball_pos.x <= brick_x + 8'(`BRICK_W - 1);
	end

	for (genvar i = 0; i < `NUM_BRICKS; i++) begin : g_colour
		assign brick_colour[i] = alive[i] ? `CLR_GREEN : `CLR_BLACK;
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			alive <= '1;
			brick_hit <= 1'b0;
		end else if (load_init) begin
			alive <= '1; // Fresh wall
			brick_hit <= 1'b0;
		end else begin
			brick_hit <= brick_check && hit_now; // Ball turns on this pulse
			if (brick_check && hit_now)
				alive[brick_idx] <= 1'b0;
		end
	end

	// Each hit takes out a brick that was standing on the check cycle
	hit_kills_live_brick: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		brick_hit |-> $past(brick_check) && (($past(alive) & ~alive) != '0));

endmodule

/* breakout_top.sv */
// Ends at a pixel-plot stream that must be taken every cycle; rst_n is the only restart
`timescale 1ns/1ps
`include "breakout_macros.svh"

module breakout_top #(
	parameter int frame_cycles = `FRAME_CYCLES_DEFAULT
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  breakout_pkg::keys_t keys,
	output breakout_pkg::pixel_t pixel,
	output logic plot
);
	logic tick;
	logic start;
	logic done;
	logic dead;
	logic load_init;
	logic paddle_step;
	logic ball_step;
	logic brick_check;
	logic brick_hit;
	logic [2:0] brick_idx;
	breakout_pkg::draw_req_t draw_req;
	breakout_pkg::point_t paddle_pos;
	breakout_pkg::point_t ball_pos;
	logic [`NUM_BRICKS-1:0][`COLOUR_W-1:0] brick_colour;

	frame_tick #(.frame_cycles(frame_cycles)) frame_tick_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .tick(tick)
	);

	game_fsm game_fsm_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .tick(tick), .done(done), .dead(dead),
		.paddle_pos(paddle_pos), .ball_pos(ball_pos), .brick_colour(brick_colour),
		.start(start), .draw_req(draw_req), .load_init(load_init),
		.paddle_step(paddle_step), .ball_step(ball_step),
		.brick_check(brick_check), .brick_idx(brick_idx)
	);

	sprite_raster sprite_raster_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .start(start), .draw_req(draw_req),
		.pixel(pixel), .plot(plot), .done(done)
	);

	paddle_unit paddle_unit_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .load_init(load_init),
		.paddle_step(paddle_step), .keys(keys), .paddle_pos(paddle_pos)
	);

	ball_unit ball_unit_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .load_init(load_init), .ball_step(ball_step),
		.paddle_pos(paddle_pos), .brick_hit(brick_hit), .ball_pos(ball_pos), .dead(dead)
	);

	brick_wall brick_wall_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .load_init(load_init),
		.brick_check(brick_check), .brick_idx(brick_idx), .ball_pos(ball_pos),
		.brick_hit(brick_hit), .brick_colour(brick_colour)
	);

endmodule

/* tb_breakout.sv */
// Checks every plotted pixel in order against a game model; frame_cycles must cover one frame
`timescale 1ns/1ps
`include "breakout_macros.svh"

module tb_breakout;
	localparam int frame_cycles = 400;
	localparam int max_frames = 600;
	localparam int screen_px = 65536;
	// Clear and fill sweeps plus every frame times two
	localparam longint watchdog_ns = 2 * (2 * screen_px + max_frames * frame_cycles) * 20;

	logic CLOCK_50;
	logic rst_n;
	breakout_pkg::keys_t keys;
	breakout_pkg::pixel_t pixel;
	logic plot;

	integer seed;
	integer rnd;
	int frames;
	event frame_end; // Last brick of a frame seen

	// Modelled game state
	logic [`COORD_W-1:0] pad_x;
	logic [`COORD_W-1:0] ball_x;
	logic [`COORD_W-1:0] ball_y;
	logic x_left;
	logic y_down;
	logic ball_dead;
	logic [`NUM_BRICKS-1:0] alive;

	breakout_top #(.frame_cycles(frame_cycles)) dut_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .keys(keys), .pixel(pixel), .plot(plot)
	);

	always #10 CLOCK_50 = ~CLOCK_50;

	// Pixel k of a w-wide rectangle in row order with 8-bit wrap
	function automatic breakout_pkg::pixel_t expected_pixel(input int bx, input int by,
		input int w, input logic [`COLOUR_W-1:0] colour, input int k);
		breakout_pkg::pixel_t p;
		p.point.x = 8'((bx + k % w) & 255);
		p.point.y = 8'((by + k / w) & 255); // Screen sweep is w = 256 from 0,0
		p.colour = colour;
		return p;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
			$display("test failed");
			$fatal(1, "Pixel stream mismatch");
		end
	endtask

	// Next plotted pixel, sampled mid-cycle
	task automatic wait_pixel();
		@(negedge CLOCK_50);
		while (plot !== 1'b1)
			@(negedge CLOCK_50);
	endtask

	task automatic expect_draw(input int bx, input int by, input int w, input int h,
		input logic [`COLOUR_W-1:0] colour);
		breakout_pkg::pixel_t exp;
		for (int k = 0; k < w * h; k++) begin
			wait_pixel();
			exp = expected_pixel(bx, by, w, colour, k);
			check_value("pixel.point.x", pixel.point.x, exp.point.x);
			check_value("pixel.point.y", pixel.point.y, exp.point.y);
			check_value("pixel.colour", pixel.colour, exp.colour);
		end
	endtask

	task automatic move_paddle();
		if (keys.right && pad_x < `PADDLE_X_MAX)
			pad_x = pad_x + 8'd1;
		if (keys.left && pad_x > 0) // Tested after the right step
			pad_x = pad_x - 8'd1;
	endtask

	task automatic move_ball();
		logic [`COORD_W-1:0] nx;
		logic [`COORD_W-1:0] ny;
		logic hit_paddle;
		nx = x_left ? ball_x - 8'd1 : ball_x + 8'd1;
		ny = y_down ? ball_y + 8'd1 : ball_y - 8'd1;
		hit_paddle = y_down && (ny == `PADDLE_Y0 || ny == `PADDLE_Y0 + 1) &&
			nx >= pad_x && nx <= pad_x + `PADDLE_W - 1;
		if (nx == 0 || nx == `SCREEN_W)
			x_left = ~x_left; // Side walls
		if (ny == 0 || hit_paddle)
			y_down = ~y_down;
		if (ny >= `SCREEN_H)
			ball_dead = 1'b1;
		ball_x = nx;
		ball_y = ny;
	endtask

	task automatic check_brick(input int i);
		int bx;
		bx = `BRICK_X0 + `BRICK_PITCH * i;
		if (alive[i] && (ball_y == `BRICK_ROW_Y || ball_y == `BRICK_ROW_Y + 1) &&
			ball_x >= bx && ball_x <= bx + `BRICK_W - 1) begin
			alive[i] = 1'b0;
			y_down = ~y_down; // One flip per knocked out brick
		end
	endtask

	initial begin
		CLOCK_50 = 1'b0;
		rst_n = 1'b0;
		seed = 50;
		rnd = $random(seed);
		keys = rnd[1:0]; // Pair for frame 1
		repeat (2) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst_n = 1'b1;
	end

	// Fresh key pair once per frame ahead of the next paddle move
	always begin
		@(frame_end);
		@(negedge CLOCK_50);
		rnd = $random(seed);
		keys = rnd[1:0];
	end

	initial begin : comparer
		frames = 0;
		pad_x = `PADDLE_X0;
		ball_x = `BALL_X0;
		ball_y = `BALL_Y0;
		x_left = 1'b0;
		y_down = 1'b0;
		ball_dead = 1'b0;
		alive = '1;
		expect_draw(0, 0, 256, 256, `CLR_BLACK);
		expect_draw(pad_x, `PADDLE_Y0, `PADDLE_W, `PADDLE_H, `CLR_WHITE);
		expect_draw(ball_x, ball_y, 1, 1, `CLR_WHITE);
		while (!ball_dead && frames < max_frames) begin
			expect_draw(pad_x, `PADDLE_Y0, `PADDLE_W, `PADDLE_H, `CLR_BLACK);
			move_paddle();
			expect_draw(pad_x, `PADDLE_Y0, `PADDLE_W, `PADDLE_H, `CLR_WHITE);
			expect_draw(ball_x, ball_y, 1, 1, `CLR_BLACK);
			move_ball();
			if (!ball_dead) begin
				expect_draw(ball_x, ball_y, 1, 1, `CLR_WHITE);
				for (int i = 0; i < `NUM_BRICKS; i++) begin
					check_brick(i);
					expect_draw(`BRICK_X0 + `BRICK_PITCH * i, `BRICK_ROW_Y, `BRICK_W,
						`BRICK_H, alive[i] ? `CLR_GREEN : `CLR_BLACK);
				end
				frames++;
				-> frame_end;
			end
		end
		if (ball_dead) begin
			expect_draw(0, 0, 256, 256, `CLR_RED); // Game over fill
			repeat (2 * frame_cycles) begin
				@(negedge CLOCK_50);
				check_value("plot", plot, 1'b0); // Halted
			end
		end
		$display("test passed");
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Timeout: the game did not finish within %0d ns", watchdog_ns);
		$display("test failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* verilog.f */
+incdir+.
breakout_pkg.sv
frame_tick.sv
sprite_raster.sv
game_fsm.sv
paddle_unit.sv
ball_unit.sv
brick_wall.sv
breakout_top.sv
tb_breakout.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_breakout -f verilog.f &&
./obj_dir/Vtb_breakout | tee /dev/stderr | grep -q "test passed" &&
echo "Simulation OK" ||
{ echo "Simulation FAILED"; exit 1; }
